/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;

    // write-back source select.
    localparam logic [1:0] wb_sel_alu = 2'd0;
    localparam logic [1:0] wb_sel_mem = 2'd1;
    localparam logic [1:0] wb_sel_pc4 = 2'd2;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_op     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10  // lui result.
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    a_is_pc;
        logic    jump;
        logic    branch;
    } ex_ctrl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;   // size and sign.
    } mem_ctrl_t;

    typedef struct packed {
        logic       reg_write;
        logic [1:0] wb_sel;
    } wb_ctrl_t;

    typedef struct packed {
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            valid;
    } fetch_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  we;
    } wb_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rdata1;
        logic [xlen-1:0]       rdata2;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       pc;
    } id_ex_t;

endpackage

`default_nettype wire

/* src/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen import rv_pkg::*; (
    input  logic [xlen-1:0] inst,
    output logic [xlen-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(inst[6:0]);

    always_comb begin
        case (opcode)
            op_jalr, op_load, op_imm: begin
                imm = {{20{inst[31]}}, inst[31:20]};  // i-type.
            end
            op_store: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            op_branch: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            op_lui, op_auipc: begin
                imm = {inst[31:12], 12'b0};
            end
            op_jal: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // r-type and unknown.
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  wb_t                   wb,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [nregs];
    logic            wr_en;

    assign wr_en = wb.we && (wb.rd != '0);  // x0 never written.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is visible on read.
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else if (wr_en && (wb.rd == raddr1)) begin
            rdata1 = wb.data;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else if (wr_en && (wb.rd == raddr2)) begin
            rdata2 = wb.data;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import rv_pkg::*; (
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  uses_rs2,
    input  logic                  ex_mem_read,
    output logic                  stall
);

    logic rs1_hit;
    logic rs2_hit;

    assign rs1_hit = (ex_rd == rs1);
    assign rs2_hit = uses_rs2 && (ex_rd == rs2);

    // load result not ready until after mem.
    assign stall = ex_mem_read && (ex_rd != '0) && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

/* src/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit import rv_pkg::*; (
    input  logic [xlen-1:0] inst,
    output ctrl_t           ctrl,
    output logic            uses_rs2,
    output logic            uj_type,
    output logic            illegal
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       f7_alt;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign f7_alt = inst[30];

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl     = '0;
        uses_rs2 = 1'b0;
        uj_type  = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            op_lui: begin
                ctrl.ex.alu_op      = alu_pass_b;
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.wb.reg_write   = 1'b1;
                ctrl.wb.wb_sel      = wb_sel_alu;
                uj_type             = 1'b1;
            end
            op_auipc: begin
                ctrl.ex.alu_op      = alu_add;
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.ex.a_is_pc     = 1'b1;
                ctrl.wb.reg_write   = 1'b1;
                ctrl.wb.wb_sel      = wb_sel_alu;
                uj_type             = 1'b1;
            end
            op_jal: begin
                ctrl.ex.alu_op      = alu_add;  // target = pc + imm.
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.ex.a_is_pc     = 1'b1;
                ctrl.ex.jump        = 1'b1;
                ctrl.wb.reg_write   = 1'b1;
                ctrl.wb.wb_sel      = wb_sel_pc4;
                uj_type             = 1'b1;
            end
            op_jalr: begin
                ctrl.ex.alu_op      = alu_add;
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.ex.jump        = 1'b1;
                ctrl.wb.reg_write   = 1'b1;
                ctrl.wb.wb_sel      = wb_sel_pc4;
            end
            op_branch: begin
                // compare in alu, funct3 picks the test.
                case (funct3[2:1])
                    2'b10:   ctrl.ex.alu_op = alu_slt;
                    2'b11:   ctrl.ex.alu_op = alu_sltu;
                    default: ctrl.ex.alu_op = alu_sub;
                endcase
                ctrl.ex.branch = 1'b1;
                uses_rs2       = 1'b1;
            end
            op_load: begin
                ctrl.ex.alu_op      = alu_add;
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.mem.mem_read   = 1'b1;
                ctrl.mem.funct3     = funct3;
                ctrl.wb.reg_write   = 1'b1;
                ctrl.wb.wb_sel      = wb_sel_mem;
            end
            op_store: begin
                ctrl.ex.alu_op      = alu_add;
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.mem.mem_write  = 1'b1;
                ctrl.mem.funct3     = funct3;
                uses_rs2            = 1'b1;
            end
            op_imm: begin
                // no subi, alt bit only for srai.
                ctrl.ex.alu_op      = alu_decode(funct3, f7_alt && (funct3 == 3'b101));
                ctrl.ex.alu_src_imm = 1'b1;
                ctrl.wb.reg_write   = 1'b1;
                ctrl.wb.wb_sel      = wb_sel_alu;
            end
            op_op: begin
                ctrl.ex.alu_op    = alu_decode(funct3, f7_alt);
                ctrl.wb.reg_write = 1'b1;
                ctrl.wb.wb_sel    = wb_sel_alu;
                uses_rs2          = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/stage_id.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_id import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_t                if_id,
    input  wb_t                   wb,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  ex_mem_read,
    output logic                  stall,
    output id_ex_t                id_next
);

    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [xlen-1:0]       imm, rdata1, rdata2;
    ctrl_t                 ctrl;
    logic                  uses_rs2, uj_type, illegal;
    logic                  hazard;

    assign rs1 = uj_type ? '0 : if_id.inst[19:15];  // u/j have no rs1.
    assign rs2 = if_id.inst[24:20];
    assign rd  = if_id.inst[11:7];

    assign stall = hazard && if_id.valid;

    imm_gen u_imm_gen (
        .inst (if_id.inst),
        .imm
    );

    reg_file u_reg_file (
        .clk,
        .rst_n,
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wb,
        .rdata1,
        .rdata2
    );

    hazard_unit u_hazard_unit (
        .rs1,
        .rs2,
        .ex_rd,
        .uses_rs2,
        .ex_mem_read,
        .stall (hazard)
    );

    control_unit u_control_unit (
        .inst (if_id.inst),
        .ctrl,
        .uses_rs2,
        .uj_type,
        .illegal
    );

    always_comb begin
        id_next.valid   = if_id.valid;
        id_next.illegal = if_id.valid && illegal;
        id_next.ctrl    = (stall || !if_id.valid) ? '0 : ctrl;
        id_next.rs1     = rs1;
        id_next.rs2     = rs2;
        id_next.rd      = rd;
        id_next.rdata1  = rdata1;
        id_next.rdata2  = rdata2;
        id_next.imm     = imm;
        id_next.pc      = if_id.pc;
    end

endmodule

`default_nettype wire

/* src/if_id_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module if_id_reg import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  fetch_t fetch,
    input  logic   stall,
    output fetch_t if_id
);

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id <= fetch;  // valid follows fetch.valid.
        end
        if (!rst_n) begin
            if_id.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/id_ex_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  id_ex_t                id_next,
    output id_ex_t                id_ex,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  ex_mem_read
);

    always_ff @(posedge clk) begin
        id_ex <= id_next;
        // bubble: payload don't care, control cleared.
        if (!rst_n || stall) begin
            id_ex.valid   <= 1'b0;
            id_ex.illegal <= 1'b0;
            id_ex.ctrl    <= '0;
        end
    end

    // feedback to hazard check.
    assign ex_rd       = id_ex.valid ? id_ex.rd : '0;
    assign ex_mem_read = id_ex.valid && id_ex.ctrl.mem.mem_read;

endmodule

`default_nettype wire

/* src/id_top.sv */
`timescale 1ns/1ns
`default_nettype none

module id_top import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  fetch_t fetch,
    output logic   ready,
    input  wb_t    wb,
    output id_ex_t id_ex
);

    fetch_t                if_id;
    id_ex_t                id_next;
    logic                  stall;
    logic [reg_addr_w-1:0] ex_rd;
    logic                  ex_mem_read;

    assign ready = ~stall;  // only the hazard back-pressures.

    if_id_reg u_if_id_reg (
        .clk,
        .rst_n,
        .fetch,
        .stall,
        .if_id
    );

    stage_id u_stage_id (
        .clk,
        .rst_n,
        .if_id,
        .wb,
        .ex_rd,
        .ex_mem_read,
        .stall,
        .id_next
    );

    id_ex_reg u_id_ex_reg (
        .clk,
        .rst_n,
        .stall,
        .id_next,
        .id_ex,
        .ex_rd,
        .ex_mem_read
    );

endmodule

`default_nettype wire

/* dv/tb_id_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_top import rv_pkg::*; ();

    logic   clk;
    logic   rst_n;
    fetch_t fetch;
    logic   ready;
    wb_t    wb;
    id_ex_t id_ex;

    logic [31:0]     lfsr;
    logic [xlen-1:0] shadow [nregs];
    fetch_t          m_ifid;      // model of the IF/ID register.
    logic            m_ex_load;
    logic [4:0]      m_ex_rd;
    id_ex_t          exp_q [$];
    int              errors;
    int              checks;
    int              accepted;
    int              completed;
    int              stalls;
    int              hold_cnt;
    logic            timed_out;

    id_top dut (
        .clk,
        .rst_n,
        .fetch,
        .ready,
        .wb,
        .id_ex
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [xlen-1:0] reg_read(input logic [4:0] addr, input wb_t w);
        if (addr == 5'd0) begin
            return '0;
        end
        if (w.we && w.rd == addr) begin
            return w.data;  // same-cycle write.
        end
        return shadow[addr];
    endfunction

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? alu_sub : alu_add;
            3'd1:    return alu_sll;
            3'd2:    return alu_slt;
            3'd3:    return alu_sltu;
            3'd4:    return alu_xor;
            3'd5:    return alt ? alu_sra : alu_srl;
            3'd6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // expected decode of one instruction.
    function automatic id_ex_t ref_decode(input logic [31:0] inst, input logic [31:0] pc,
                                          input wb_t w);
        id_ex_t     e;
        logic [6:0] op;
        logic [2:0] f3;
        e     = '0;
        op    = inst[6:0];
        f3    = inst[14:12];
        e.valid = 1'b1;
        e.rd  = inst[11:7];
        e.rs2 = inst[24:20];
        e.rs1 = (op == op_lui || op == op_auipc || op == op_jal) ? 5'd0 : inst[19:15];
        e.pc  = pc;
        if (op == op_lui || op == op_auipc) begin
            e.imm                  = {inst[31:12], 12'b0};
            e.ctrl.ex.alu_op       = (op == op_lui) ? alu_pass_b : alu_add;
            e.ctrl.ex.a_is_pc      = (op == op_auipc);
            e.ctrl.ex.alu_src_imm  = 1'b1;
            e.ctrl.wb.reg_write    = 1'b1;
        end else if (op == op_jal || op == op_jalr) begin
            if (op == op_jal) begin
                e.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end else begin
                e.imm = {{20{inst[31]}}, inst[31:20]};
            end
            e.ctrl.ex.alu_op      = alu_add;
            e.ctrl.ex.a_is_pc     = (op == op_jal);
            e.ctrl.ex.alu_src_imm = 1'b1;
            e.ctrl.ex.jump        = 1'b1;
            e.ctrl.wb.reg_write   = 1'b1;
            e.ctrl.wb.wb_sel      = wb_sel_pc4;
        end else if (op == op_branch) begin
            e.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            e.ctrl.ex.alu_op = (f3 == 3'd4 || f3 == 3'd5) ? alu_slt :
                               (f3 == 3'd6 || f3 == 3'd7) ? alu_sltu : alu_sub;
            e.ctrl.ex.branch = 1'b1;
        end else if (op == op_load || op == op_store) begin
            e.imm = (op == op_load) ? {{20{inst[31]}}, inst[31:20]}
                                    : {{20{inst[31]}}, inst[31:25], inst[11:7]};
            e.ctrl.ex.alu_op       = alu_add;
            e.ctrl.ex.alu_src_imm  = 1'b1;
            e.ctrl.mem.mem_read    = (op == op_load);
            e.ctrl.mem.mem_write   = (op == op_store);
            e.ctrl.mem.funct3      = f3;
            e.ctrl.wb.reg_write    = (op == op_load);
            e.ctrl.wb.wb_sel       = (op == op_load) ? wb_sel_mem : wb_sel_alu;
        end else if (op == op_imm) begin
            e.imm                 = {{20{inst[31]}}, inst[31:20]};
            e.ctrl.ex.alu_op      = arith_op(f3, inst[30] && f3 == 3'd5);
            e.ctrl.ex.alu_src_imm = 1'b1;
            e.ctrl.wb.reg_write   = 1'b1;
        end else if (op == op_op) begin
            e.ctrl.ex.alu_op    = arith_op(f3, inst[30]);
            e.ctrl.wb.reg_write = 1'b1;
        end else begin
            e.illegal = 1'b1;
        end
        e.rdata1 = reg_read(e.rs1, w);
        e.rdata2 = reg_read(e.rs2, w);
        return e;
    endfunction

    function automatic logic [6:0] pick_opcode();
        logic [3:0] idx;
        idx = rand_bits(4);
        case (idx)
            4'd0: return op_lui;
            4'd1: return op_auipc;
            4'd2: return op_jal;
            4'd3: return op_jalr;
            4'd4: return op_branch;
            4'd5: return op_store;
            4'd6: return op_imm;
            4'd7: return op_op;
            4'd8: return op_op;
            4'd9: return 7'b0001111;  // fence is unknown here.
            4'd10: return 7'b1111111;
            default: return op_load;  // loads weighted for hazards.
        endcase
    endfunction

    // one falling-edge step of stimulus and prediction.
    task automatic step(input logic allow_fetch);
        logic [6:0]  op;
        logic [4:0]  r1;
        logic        use2;
        logic        stall_exp;
        id_ex_t      exp;
        wb_t         wb_n;
        fetch_t      fetch_n;
        op   = m_ifid.inst[6:0];
        r1   = (op == op_lui || op == op_auipc || op == op_jal) ? 5'd0 : m_ifid.inst[19:15];
        use2 = (op == op_branch || op == op_store || op == op_op);
        stall_exp = m_ifid.valid && m_ex_load && m_ex_rd != 5'd0 &&
                    (m_ex_rd == r1 || (use2 && m_ex_rd == m_ifid.inst[24:20]));
        check(ready, !stall_exp, "ready");
        if (stall_exp) begin
            stalls++;
        end
        if (!ready) begin
            hold_cnt++;
            if (hold_cnt > 4) begin
                $display("timeout: ready stayed low for %0d cycles", hold_cnt);
                errors++;
                timed_out = 1'b1;
            end
        end else begin
            hold_cnt = 0;
        end
        wb_n.we   = rand_bits(1);
        wb_n.rd   = rand_bits(3);
        wb_n.data = rand_bits(32);
        exp = '0;
        if (!stall_exp && m_ifid.valid) begin
            exp = ref_decode(m_ifid.inst, m_ifid.pc, wb_n);
        end
        exp_q.push_back(exp);
        fetch_n = fetch;  // held while stalled.
        if (!stall_exp) begin
            fetch_n.valid = allow_fetch && (rand_bits(2) != 2'd0);
            if (fetch_n.valid) begin
                fetch_n.inst        = rand_bits(32);
                fetch_n.inst[6:0]   = pick_opcode();
                fetch_n.inst[11:7]  = rand_bits(3);
                fetch_n.inst[19:15] = rand_bits(3);
                fetch_n.inst[24:20] = rand_bits(3);
                fetch_n.pc          = fetch.pc + 32'd4;
                accepted++;
            end
            m_ifid = fetch_n;
        end
        m_ex_load = exp.valid && exp.ctrl.mem.mem_read;
        m_ex_rd   = exp.rd;
        if (wb_n.we && wb_n.rd != 5'd0) begin
            shadow[wb_n.rd] = wb_n.data;
        end
        fetch = fetch_n;
        wb    = wb_n;
    endtask

    // compare id_ex after each rising edge.
    initial begin
        id_ex_t exp;
        forever begin
            @(posedge clk);
            #10;
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                check(id_ex.valid, exp.valid, "id_ex.valid");
                check(id_ex.illegal, exp.illegal, "id_ex.illegal");
                check(id_ex.ctrl, exp.ctrl, "id_ex.ctrl");
                if (exp.valid) begin
                    check(id_ex.pc, exp.pc, "id_ex.pc");
                    check(id_ex.imm, exp.imm, "id_ex.imm");
                    check({id_ex.rs1, id_ex.rs2, id_ex.rd}, {exp.rs1, exp.rs2, exp.rd},
                          "register fields");
                    check(id_ex.rdata1, exp.rdata1, "id_ex.rdata1");
                    check(id_ex.rdata2, exp.rdata2, "id_ex.rdata2");
                end
                if (id_ex.valid) begin
                    completed++;
                end
            end
        end
    end

    initial begin
        int waited;
        fetch     = '0;
        wb        = '0;
        rst_n     = 1'b0;
        lfsr      = 32'h4b1c;
        m_ifid    = '0;
        m_ex_load = 1'b0;
        m_ex_rd   = '0;
        errors    = 0;
        checks    = 0;
        accepted  = 0;
        completed = 0;
        stalls    = 0;
        hold_cnt  = 0;
        timed_out = 1'b0;
        for (int i = 0; i < nregs; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check(ready, 1'b1, "ready after reset");
        check(id_ex.valid, 1'b0, "id_ex.valid after reset");
        check(id_ex.ctrl, '0, "id_ex.ctrl after reset");
        for (int i = 0; i < 600 && !timed_out; i++) begin
            step(1'b1);
            @(negedge clk);
        end
        waited = 0;
        while (completed != accepted && waited < 20 && !timed_out) begin
            step(1'b0);
            @(negedge clk);
            waited++;
        end
        if (completed != accepted) begin
            $display("timeout: %0d instructions accepted but only %0d left id_ex",
                     accepted, completed);
            errors++;
        end
        $display("errors %0d, checks %0d, accepted %0d, stalls %0d",
                 errors, checks, accepted, stalls);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
src/rv_pkg.sv
src/imm_gen.sv
src/reg_file.sv
src/hazard_unit.sv
src/control_unit.sv
src/stage_id.sv
src/if_id_reg.sv
src/id_ex_reg.sv
src/id_top.sv
dv/tb_id_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wall
TOP       ?= tb_id_top
FLIST     ?= flist.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
